//--- rtl/MemoryAccessTester_consts.svh
// Sizes for the tester. Buffer depth and address width must agree, and the turn index must be below the depth
`ifndef MEMORY_ACCESS_TESTER_CONSTS_SVH
`define MEMORY_ACCESS_TESTER_CONSTS_SVH

// RAM data lines
`define AT_DQ_WIDTH     16

// Words per buffer, pattern and capture alike
`define AT_BUF_DEPTH    256

// Buffer address and fetch index width
`define AT_ADDR_WIDTH   8

// Command word plus address words
`define AT_TURN_INDEX   8     // First index driven by the device in read mode

`endif

//--- rtl/ramBusPkg.sv
// RAM-side types only. The bus word width is fixed by the constants header
`default_nettype none

`include "MemoryAccessTester_consts.svh"

package ramBusPkg;

	// One word on the data lines
	typedef logic [`AT_DQ_WIDTH-1:0] tDqWord;

	// Position in the pattern
	typedef logic [`AT_ADDR_WIDTH-1:0] tPatIndex;	// Wraps at buffer depth

endpackage

`default_nettype wire

//--- rtl/mcuPortPkg.sv
// MCU-side types only. The divider setting is 8 bits and must be held during a run
`default_nettype none

`include "MemoryAccessTester_consts.svh"

package mcuPortPkg;

	typedef logic [`AT_ADDR_WIDTH-1:0] tMemAddr;	// Buffer word address

	// Half period of the bus clock is this value plus one
	typedef logic [7:0] tClkDiv;

endpackage

`default_nettype wire

//--- rtl/patternFetchIf.sv
// Pattern fetch link. The word lags the index by one cycle and there is no back-pressure
`default_nettype none

interface patternFetchIf;

	logic                step;	// One-cycle advance pulse
	ramBusPkg::tDqWord   word;	// Registered word at index
	ramBusPkg::tPatIndex index;	// Current fetch position
	logic                last;	// Index at final position

	// Sequencer side
	// The top level taps word for the data lines
	modport fetcher
	(
		output step,
		input  index,
		input  last
	);

	// Buffer side
	modport source
	(
		input  step,
		output word,
		output index,
		output last
	);

endinterface

`default_nettype wire

//--- rtl/patternBuffer.sv
// MCU writes land one cycle before they can be fetched. Fetch index only clears on iRST
`default_nettype none

`include "MemoryAccessTester_consts.svh"

module patternBuffer
(
	input  logic                 iCLK,
	input  logic                 iRST,
	input  logic                 iMemWe,
	input  mcuPortPkg::tMemAddr  iMemWa,
	input  ramBusPkg::tDqWord    iMemWd,
	patternFetchIf.source        fetch
);

	ramBusPkg::tDqWord   rPatMem [0:`AT_BUF_DEPTH-1];	// Cmd, address, then data
	ramBusPkg::tPatIndex rIndex;

	// Pattern memory with registered sequential read
	always_ff @(posedge iCLK)
	begin
		if (iMemWe)
			rPatMem[iMemWa] <= iMemWd;	// MCU load port
		fetch.word <= rPatMem[rIndex];	// Follows index by one cycle
	end

	// Fetch position
	always_ff @(posedge iCLK)
	begin
		if (iRST)
			rIndex <= '0;
		else if (fetch.step)
			rIndex <= rIndex + 1'b1;	// One word per bus clock rise
	end

	assign fetch.index = rIndex;

	// Final word flag, a level
	assign fetch.last = (rIndex == ramBusPkg::tPatIndex'(`AT_BUF_DEPTH - 1));

endmodule

`default_nettype wire

//--- rtl/busSequencer.sv
// Divider must stay constant during a run. Done is sticky and a new run needs iRST first
`default_nettype none

`include "MemoryAccessTester_consts.svh"

module busSequencer
(
	input  logic                iCLK,
	input  logic                iRST,
	input  logic                iTestEn,
	input  logic                iMemWdOe,	// High for write runs
	input  mcuPortPkg::tClkDiv  iMemClkDiv,
	patternFetchIf.fetcher      fetch,
	output logic                oTestCs,
	output logic                oTestClk,
	output logic                oTestOe,
	output logic                oTestEn,
	output logic                oTestDone
);

	mcuPortPkg::tClkDiv rDivCnt;	// Half period counter
	logic qTestRun;
	logic qDivTick;
	logic qStep;
	logic qOeCke;

	always_comb
	begin
		qTestRun = iTestEn & ~oTestDone;	// Enable level gated by done
		// Divider end, only while the bus is selected
		qDivTick = ~oTestCs & (rDivCnt == iMemClkDiv);
		qStep    = qDivTick & ~oTestClk;	// Tick that raises the bus clock
		// Step from the last address word into the data phase
		qOeCke   = qStep & ~iMemWdOe
			& (fetch.index == ramBusPkg::tPatIndex'(`AT_TURN_INDEX - 1));
	end

	assign fetch.step = qStep;

	// Chip select and run indication
	always_ff @(posedge iCLK)
	begin
		if (iRST)
		begin
			oTestCs <= 1'b1;
			oTestEn <= 1'b0;
		end
		else
		begin
			oTestCs <= ~qTestRun;	// Low while running
			oTestEn <= qTestRun;
		end
	end

	// Clock divider
	always_ff @(posedge iCLK)
	begin
		if (iRST)
			rDivCnt <= '0;
		else if (qDivTick)
			rDivCnt <= '0;
		else if (~oTestCs)
			rDivCnt <= rDivCnt + 1'b1;
	end

	// Bus clock, toggled per tick
	always_ff @(posedge iCLK)
	begin
		if (iRST)
			oTestClk <= 1'b0;
		else if (qDivTick)
			oTestClk <= ~oTestClk;
	end

	// Direction and completion, both one-way until reset
	always_ff @(posedge iCLK)
	begin
		if (iRST)
		begin
			oTestOe   <= 1'b1;	// Write direction
			oTestDone <= 1'b0;
		end
		else
		begin
			if (qOeCke)
				oTestOe <= 1'b0;	// Device drives from here
			if (fetch.last)
				oTestDone <= 1'b1;	// Pattern exhausted
		end
	end

endmodule

`default_nettype wire

//--- rtl/captureBuffer.sv
// Capture pointer wraps after 256 strobes and only clears on iRST. MCU reads lag by one cycle
`default_nettype none

`include "MemoryAccessTester_consts.svh"

module captureBuffer
(
	input  logic                 iCLK,
	input  logic                 iRST,
	input  logic                 iTestRe,	// Receive strobe from device side
	input  ramBusPkg::tDqWord    iTestRd,
	input  mcuPortPkg::tMemAddr  iMemRa,
	output ramBusPkg::tDqWord    oMemRd
);

	ramBusPkg::tDqWord   rCapMem [0:`AT_BUF_DEPTH-1];
	mcuPortPkg::tMemAddr rCapPtr;	// Next free slot

	// Device words in arrival order
	always_ff @(posedge iCLK)
	begin
		if (iTestRe)
			rCapMem[rCapPtr] <= iTestRd;
		oMemRd <= rCapMem[iMemRa];	// Registered MCU read
	end

	// Write pointer
	always_ff @(posedge iCLK)
	begin
		if (iRST)
			rCapPtr <= '0;
		else if (iTestRe)
			rCapPtr <= rCapPtr + 1'b1;
	end

endmodule

`default_nettype wire

//--- rtl/MemoryAccessTester.sv
// MCU loads the pattern with commands 0x38 or 0xEB itself. The device model drives iTestRe and iTestRd
`default_nettype none

module MemoryAccessTester
(
	input  logic                 iCLK,
	input  logic                 iRST,
	// Control and status
	input  logic                 iTestEn,
	input  logic                 iMemWdOe,	// Low selects read run
	// MCU buffer ports
	input  logic                 iMemWe,
	input  mcuPortPkg::tMemAddr  iMemWa,
	input  ramBusPkg::tDqWord    iMemWd,
	input  mcuPortPkg::tMemAddr  iMemRa,
	input  mcuPortPkg::tClkDiv   iMemClkDiv,
	// Device receive path
	input  logic                 iTestRe,
	input  ramBusPkg::tDqWord    iTestRd,
	// RAM bus
	output ramBusPkg::tDqWord    oTestDq,
	output logic                 oTestCs,
	output logic                 oTestClk,
	output logic                 oTestOe,
	output logic                 oTestEn,
	output logic                 oTestDone,
	output ramBusPkg::tDqWord    oMemRd
);

	patternFetchIf fetchBus();	// Buffer to sequencer link

	patternBuffer uPatternBuffer
	(
		.iCLK   (iCLK),
		.iRST   (iRST),
		.iMemWe (iMemWe),
		.iMemWa (iMemWa),
		.iMemWd (iMemWd),
		.fetch  (fetchBus)
	);

	busSequencer uBusSequencer
	(
		.iCLK       (iCLK),
		.iRST       (iRST),
		.iTestEn    (iTestEn),
		.iMemWdOe   (iMemWdOe),
		.iMemClkDiv (iMemClkDiv),
		.fetch      (fetchBus),
		.oTestCs    (oTestCs),
		.oTestClk   (oTestClk),
		.oTestOe    (oTestOe),
		.oTestEn    (oTestEn),
		.oTestDone  (oTestDone)
	);

	captureBuffer uCaptureBuffer
	(
		.iCLK    (iCLK),
		.iRST    (iRST),
		.iTestRe (iTestRe),
		.iTestRd (iTestRd),
		.iMemRa  (iMemRa),
		.oMemRd  (oMemRd)
	);

	assign oTestDq = fetchBus.word;	// Registered pattern word onto the data lines

endmodule

`default_nettype wire

//--- tb/tbClockGen.sv
// Free-running 100 ns clock. Power-on reset spans 16 rising edges and drops 10 ns after the last
`default_nettype none

module tbClockGen
(
	output logic clk,
	output logic rst
);

	timeunit 1ns;
	timeprecision 100ps;

	localparam int HALF_PERIOD  = 50;
	localparam int RESET_CYCLES = 16;

	initial
	begin
		clk = 1'b0;
		forever #HALF_PERIOD clk = ~clk;
	end

	// Power-on reset
	initial
	begin
		rst = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		#10 rst = 1'b0;	// Same drive delay as the stimulus
	end

endmodule

`default_nettype wire

//--- tb/MemoryAccessTester_sva.sv
// Sequencer control checks only. Needs assertions enabled in the simulator, failures are counted
`default_nettype none

module MemoryAccessTesterSva
(
	input logic clk,
	input logic rst,
	input logic testCs,
	input logic testOe,
	input logic testDone,
	input logic step
);

	timeunit 1ns;
	timeprecision 100ps;

	int assertFailures = 0;	// Read by the testbench summary

	// Chip select follows done by one cycle
	csAfterDone: assert property (@(posedge clk) disable iff (rst) testDone |=> testCs)
		else
		begin
			$error("chip select low after done");
			assertFailures++;
		end

	// Turnaround is one-way until reset
	oeNoRise: assert property (@(posedge clk) disable iff (rst) !$rose(testOe))
		else
		begin
			$error("output enable rose outside reset");
			assertFailures++;
		end

	noStepDeselected: assert property (@(posedge clk) disable iff (rst) testCs |-> !step)
		else
		begin
			$error("pattern step while chip select high");
			assertFailures++;
		end

endmodule

bind busSequencer MemoryAccessTesterSva uSva
(
	.clk      (iCLK),
	.rst      (iRST),
	.testCs   (oTestCs),
	.testOe   (oTestOe),
	.testDone (oTestDone),
	.step     (qStep)
);

`default_nettype wire

//--- tb/MemoryAccessTesterTb.sv
// Four runs from seed 37822, dividers 1 to 3, at most 250 capture strobes per run
`default_nettype none

`include "MemoryAccessTester_consts.svh"

module MemoryAccessTesterTb;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int SEED         = 37822;
	localparam int DRIVE_DELAY  = 10;	// After the rising edge
	localparam int NUM_RUNS     = 4;
	localparam int MAX_DIV      = 3;
	localparam int MAX_CAPTURE  = 250;
	// Reset, pattern load, capture readback and margin per run
	localparam int RUN_OVERHEAD = 16 + 3 * `AT_BUF_DEPTH + 64;
	localparam int WATCHDOG_CYCLES = NUM_RUNS * (512 * (MAX_DIV + 1) + RUN_OVERHEAD) + 16;

	logic                iCLK;
	logic                porRst;
	logic                rstReq;	// Reset between runs
	logic                iRST;
	logic                iTestEn;
	logic                iMemWdOe;
	logic                iMemWe;
	mcuPortPkg::tMemAddr iMemWa;
	ramBusPkg::tDqWord   iMemWd;
	mcuPortPkg::tMemAddr iMemRa;
	mcuPortPkg::tClkDiv  iMemClkDiv;
	logic                iTestRe;
	ramBusPkg::tDqWord   iTestRd;
	ramBusPkg::tDqWord   oTestDq;
	logic                oTestCs;
	logic                oTestClk;
	logic                oTestOe;
	logic                oTestEn;
	logic                oTestDone;
	ramBusPkg::tDqWord   oMemRd;

	ramBusPkg::tDqWord patModel [0:`AT_BUF_DEPTH-1];	// Expected pattern
	ramBusPkg::tDqWord capModel [$];	// Expected capture, strobe order

	// Bus monitor state
	string testName;
	logic  monitorOn;
	logic  readRun;
	int    divSetting;
	logic  prevClk;
	logic  phaseSeen;
	int    cyclesSince;
	int    riseCount;
	int    fallCount;

	int errorCount;
	int testErrors;
	int testsFailed;
	int run;

	tbClockGen uClockGen (.clk(iCLK), .rst(porRst));

	assign iRST = porRst | rstReq;

	MemoryAccessTester UUT (.*);

	task automatic checkValue(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (actual !== expected)
		begin
			$display("MISMATCH %s expected %0h actual %0h", name, expected, actual);
			errorCount++;
			testErrors++;
		end
	endtask

	task automatic nextDriveSlot();
		@(posedge iCLK);
		#DRIVE_DELAY;
	endtask

	// Bus clock phases, falling edge data and direction sampled mid-cycle
	always @(negedge iCLK)
	begin
		if (monitorOn)
		begin
			cyclesSince++;
			if (oTestClk !== prevClk)
			begin
				if (phaseSeen)
					checkValue({testName, " phase"}, divSetting + 1, cyclesSince);
				phaseSeen = 1'b1;
				cyclesSince = 0;
				if (oTestClk)
					riseCount++;
				else
				begin
					fallCount++;	// n-th fall shows word n
					if (fallCount < `AT_BUF_DEPTH)
						checkValue($sformatf("%s dq %0d", testName, fallCount),
							patModel[fallCount], oTestDq);
				end
			end
			prevClk = oTestClk;
			// Read runs hand the bus over with the 8th rise
			checkValue({testName, " oe"},
				(readRun && riseCount >= `AT_TURN_INDEX) ? 0 : 1, oTestOe);
		end
	end

	task automatic applyReset();
		nextDriveSlot();
		rstReq = 1'b1;
		repeat (16) @(posedge iCLK);
		#DRIVE_DELAY;
		rstReq = 1'b0;
	endtask

	task automatic loadPattern(input logic readMode);
		int i;
		for (i = 0; i < `AT_BUF_DEPTH; i++)
		begin
			if (i == 0)
				patModel[i] = readMode ? 16'h00EB : 16'h0038;	// Command word
			else
				patModel[i] = ramBusPkg::tDqWord'($urandom);
			nextDriveSlot();
			iMemWe = 1'b1;
			iMemWa = mcuPortPkg::tMemAddr'(i);
			iMemWd = patModel[i];
		end
		nextDriveSlot();
		iMemWe = 1'b0;
	endtask

	// Enable and act as the device until done
	task automatic driveRun();
		nextDriveSlot();
		iTestEn = 1'b1;
		while (!oTestDone)
		begin
			nextDriveSlot();
			// Selected and running from the cycle after enable
			checkValue({testName, " run cs"}, 0, oTestCs);
			checkValue({testName, " run en"}, 1, oTestEn);
			if (oTestEn && capModel.size() < MAX_CAPTURE && ($urandom % 6) == 0)
			begin
				iTestRe = 1'b1;
				iTestRd = ramBusPkg::tDqWord'($urandom);
				capModel.push_back(iTestRd);
			end
			else
				iTestRe = 1'b0;
		end
		nextDriveSlot();	// Last strobe still lands
		iTestRe = 1'b0;
	endtask

	task automatic readCapture();
		int i;
		for (i = 0; i < capModel.size(); i++)
		begin
			nextDriveSlot();
			iMemRa = mcuPortPkg::tMemAddr'(i);
			@(posedge iCLK);	// Registered read
			@(negedge iCLK);
			checkValue($sformatf("%s capture %0d", testName, i), capModel[i], oMemRd);
		end
	endtask

	task automatic runTest(input string name, input logic readMode);
		int   div;
		logic holdClk;
		div = 1 + int'($urandom % MAX_DIV);
		testName = name;
		testErrors = 0;
		capModel.delete();
		nextDriveSlot();
		iTestEn = 1'b0;
		iMemWdOe = ~readMode;
		iMemClkDiv = mcuPortPkg::tClkDiv'(div);
		applyReset();
		loadPattern(readMode);
		// Idle after reset
		@(negedge iCLK);
		checkValue({name, " idle cs"}, 1, oTestCs);
		checkValue({name, " idle oe"}, 1, oTestOe);
		checkValue({name, " idle en"}, 0, oTestEn);
		checkValue({name, " idle clk"}, 0, oTestClk);
		checkValue({name, " idle done"}, 0, oTestDone);
		nextDriveSlot();
		readRun = readMode;
		divSetting = div;
		prevClk = oTestClk;
		phaseSeen = 1'b0;
		cyclesSince = 0;
		riseCount = 0;
		fallCount = 0;
		monitorOn = 1'b1;
		driveRun();
		// Finished with enable still high
		@(negedge iCLK);
		checkValue({name, " end cs"}, 1, oTestCs);
		checkValue({name, " end en"}, 0, oTestEn);
		checkValue({name, " end done"}, 1, oTestDone);
		holdClk = oTestClk;
		repeat (4 * (div + 1)) @(negedge iCLK);
		checkValue({name, " clk stopped"}, holdClk, oTestClk);
		checkValue({name, " cs held"}, 1, oTestCs);
		nextDriveSlot();
		monitorOn = 1'b0;
		iTestEn = 1'b0;
		checkValue({name, " rising edges"}, `AT_BUF_DEPTH - 1, riseCount);
		readCapture();
		if (testErrors == 0)
			$display("Test %s: ok, divider %0d, %0d words captured", name, div, capModel.size());
		else
		begin
			testsFailed++;
			$display("Test %s: failed with %0d errors", name, testErrors);
		end
	endtask

	initial
	begin
		void'($urandom(SEED));
		rstReq = 1'b0;
		iTestEn = 1'b0;
		iMemWdOe = 1'b1;
		iMemWe = 1'b0;
		iMemWa = '0;
		iMemWd = '0;
		iMemRa = '0;
		iMemClkDiv = 8'd1;
		iTestRe = 1'b0;
		iTestRd = '0;
		monitorOn = 1'b0;
		errorCount = 0;
		testsFailed = 0;
		wait (porRst === 1'b0);
		// Write and read runs alternate with a reset before each
		for (run = 0; run < NUM_RUNS; run++)
			runTest($sformatf("%s run %0d", (run % 2) ? "read" : "write", run + 1), run % 2 == 1);
		$display("Tests: %0d run, %0d failed, %0d mismatches, %0d assertion failures",
			NUM_RUNS, testsFailed, errorCount, UUT.uBusSequencer.uSva.assertFailures);
		if (errorCount == 0 && UUT.uBusSequencer.uSva.assertFailures == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

	// Watchdog sized from the longest possible runs
	initial
	begin
		repeat (WATCHDOG_CYCLES) @(posedge iCLK);
		$display("Timeout: tests did not finish within %0d clock cycles", WATCHDOG_CYCLES);
		$display("FAIL: see errors above");
		$finish;
	end

endmodule

`default_nettype wire

//--- MemoryAccessTester.f
+incdir+rtl
rtl/ramBusPkg.sv
rtl/mcuPortPkg.sv
rtl/patternFetchIf.sv
rtl/patternBuffer.sv
rtl/busSequencer.sv
rtl/captureBuffer.sv
rtl/MemoryAccessTester.sv
tb/tbClockGen.sv
tb/MemoryAccessTester_sva.sv
tb/MemoryAccessTesterTb.sv

//--- Makefile
# Verilator build and run for the memory access tester

VERILATOR ?= verilator
TOP       ?= MemoryAccessTesterTb
FILELIST  ?= MemoryAccessTester.f
OBJDIR    ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
SIMARGS   ?= +verilator+error+limit+1000
PASS_TEXT ?= PASS: all tests

SOURCES := $(wildcard rtl/*.sv rtl/*.svh tb/*.sv)
SIM     := $(OBJDIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

# Rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJDIR) -o V$(TOP)

# Status comes from the search for the pass line
run: $(SIM)
	@out="$$($(SIM) $(SIMARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_TEXT)"

clean:
	rm -rf $(OBJDIR)
